//--- build.f
+incdir+.
udp_ctrl_pkg.sv
udp_stream_if.sv
udp_port_switch.sv
udp_rdwr_engine.sv
udp_reply_builder.sv
turf_udp_ctrl.sv
tb_reg_responder.sv
tb_turf_udp_ctrl.sv

//--- tb_turf_udp_ctrl.sv
`timescale 1ns/1ps

module tb_turf_udp_ctrl;

    localparam logic [15:0] READ_PORT   = 16'd21618;
    localparam logic [15:0] WRITE_LO    = 16'd21616;
    localparam logic [15:0] WRITE_HI    = 16'd21623;
    localparam logic [15:0] WRITE_REPLY = 16'd21623;
    localparam int          LIMIT       = 2000;

    logic        aclk = 1'b0;
    logic        arst_n_i;
    logic [63:0] s_hdr_tdata_i;
    logic [15:0] s_hdr_tdest_i;
    logic        s_hdr_tvalid_i;
    logic        s_hdr_tready_o;
    logic [63:0] s_data_tdata_i;
    logic [7:0]  s_data_tkeep_i;
    logic        s_data_tlast_i;
    logic        s_data_tvalid_i;
    logic        s_data_tready_o;
    logic [63:0] m_hdr_tdata_o;
    logic [15:0] m_hdr_tuser_o;
    logic        m_hdr_tvalid_o;
    logic        m_hdr_tready_i;
    logic [63:0] m_data_tdata_o;
    logic [7:0]  m_data_tkeep_o;
    logic        m_data_tlast_o;
    logic        m_data_tvalid_o;
    logic        m_data_tready_i;
    logic        en_o;
    logic        wr_o;
    logic [27:0] adr_o;
    logic [31:0] dat_o;
    logic [31:0] dat_i;
    logic        ack_i;

    logic [1:0]  ack_delay = '0;
    logic [31:0] rng_state = 32'h1bcd;
    // 0 holds the reply side, 1 random gaps, 2 always ready
    int          ready_mode = 2;
    logic        drop_window;
    logic        bp_seen;
    int          stall_run = 0;
    logic        timed_out;
    int          errors;
    int          err_mark;
    int          tests_run;
    int          tests_failed;

    logic [63:0] cmd_q [$];
    // {wr, adr, dat}, {tdata, tuser}, {tlast, tdata}
    logic [60:0] exp_bus [$];
    logic [79:0] exp_hdr [$];
    logic [64:0] exp_data [$];
    logic [31:0] shadow [logic [27:0]];
    logic [60:0] bus_exp;
    logic [79:0] hdr_exp;
    logic [64:0] data_exp;

    always #4 aclk = ~aclk;

    turf_udp_ctrl dut_i (.*);

    tb_reg_responder mem_i (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .en_i     (en_o),
        .wr_i     (wr_o),
        .adr_i    (adr_o),
        .dat_i    (dat_o),
        .delay_i  (ack_delay),
        .dat_o    (dat_i),
        .ack_o    (ack_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    always @(negedge aclk) begin
        rng_state = xorshift32(rng_state);
        ack_delay <= rng_state[1:0];
        case (ready_mode)
            0: begin
                m_hdr_tready_i  = 1'b0;
                m_data_tready_i = 1'b0;
            end
            1: begin
                m_hdr_tready_i  = (rng_state[5:4] != 2'b00);
                m_data_tready_i = (rng_state[7:6] != 2'b00);
            end
            default: begin
                m_hdr_tready_i  = 1'b1;
                m_data_tready_i = 1'b1;
            end
        endcase
    end

    // scoreboard on every accepted bus cycle and reply beat
    always @(posedge aclk) begin
        if (arst_n_i && en_o && ack_i) begin
            if (exp_bus.size() == 0) begin
                report_error("register bus cycle that no command asked for");
            end else begin
                bus_exp = exp_bus.pop_front();
                a_bus: assert (wr_o == bus_exp[60] && adr_o == bus_exp[59:32]
                               && (!wr_o || dat_o == bus_exp[31:0]))
                    else report_error($sformatf("bus wr %0b adr %h dat %h, expected %h",
                                                wr_o, adr_o, dat_o, bus_exp));
            end
        end
        if (arst_n_i && m_hdr_tvalid_o && m_hdr_tready_i) begin
            if (exp_hdr.size() == 0) begin
                report_error("reply header that no packet asked for");
            end else begin
                hdr_exp = exp_hdr.pop_front();
                a_hdr: assert ({m_hdr_tdata_o, m_hdr_tuser_o} == hdr_exp)
                    else report_error($sformatf("reply header %h tuser %0d, expected %h",
                                                m_hdr_tdata_o, m_hdr_tuser_o, hdr_exp));
            end
        end
        if (arst_n_i && m_data_tvalid_o && m_data_tready_i) begin
            if (exp_data.size() == 0) begin
                report_error("reply qword that no command asked for");
            end else begin
                data_exp = exp_data.pop_front();
                a_data: assert ({m_data_tlast_o, m_data_tdata_o} == data_exp)
                    else report_error($sformatf("reply qword %h last %0b, expected %h",
                                                m_data_tdata_o, m_data_tlast_o, data_exp));
            end
        end
        // input stalled for a long stretch while the reply side is held
        if (s_data_tvalid_i && !s_data_tready_o && !m_hdr_tready_i && !m_data_tready_i) begin
            stall_run++;
        end else begin
            stall_run = 0;
        end
        if (stall_run >= 12) begin
            bp_seen <= 1'b1;
        end
    end

    a_drop_quiet: assert property (@(posedge aclk) disable iff (!arst_n_i)
        drop_window |-> !en_o && !m_hdr_tvalid_o && !m_data_tvalid_o)
        else report_error("bus cycle or reply while dropped packets were sent");

    a_keep_full: assert property (@(posedge aclk) disable iff (!arst_n_i)
        m_data_tvalid_o |-> m_data_tkeep_o == 8'hff)
        else report_error("reply tkeep is not all ones");

    a_reply_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
        m_data_tvalid_o && !m_data_tready_i |=>
        m_data_tvalid_o && $stable(m_data_tdata_o) && $stable(m_data_tlast_o))
        else report_error("reply qword changed while stalled");

    task automatic add_cmd(input logic [27:0] adr, input logic [31:0] dat);
        // bits 31:28 set to show they are ignored
        cmd_q.push_back({dat, 4'ha, adr});
    endtask

    task automatic expect_packet(input logic [15:0] dest, input logic [31:0] ip,
                                 input logic [15:0] peer);
        logic        is_read;
        logic        is_write;
        logic [27:0] adr;
        logic [31:0] dat;
        is_read  = (dest == READ_PORT);
        is_write = !is_read && dest >= WRITE_LO && dest <= WRITE_HI;
        if (is_read || is_write) begin
            exp_hdr.push_back({ip, peer, 16'(cmd_q.size()), is_read ? READ_PORT : WRITE_REPLY});
            foreach (cmd_q[i]) begin
                adr = cmd_q[i][27:0];
                if (is_write) begin
                    dat         = cmd_q[i][63:32];
                    shadow[adr] = dat;
                end else begin
                    dat = shadow.exists(adr) ? shadow[adr] : ({4'h0, adr} ^ 32'h5a5a5a5a);
                end
                exp_bus.push_back({is_write, adr, dat});
                exp_data.push_back({i == cmd_q.size() - 1, dat, 4'h0, adr});
            end
        end
    endtask

    task automatic wait_accept(input logic is_hdr, input string what);
        int   n;
        logic taken;
        n     = 0;
        taken = 1'b0;
        while (!taken && n < LIMIT && !timed_out) begin
            @(posedge aclk);
            taken = is_hdr ? s_hdr_tready_o : s_data_tready_o;
            n++;
        end
        if (!taken && !timed_out) begin
            timed_out = 1'b1;
            $display("timeout: the DUT never accepted the %s beat", what);
        end
    endtask

    task automatic send_packet(input logic [15:0] dest, input logic [31:0] ip,
                               input logic [15:0] peer);
        logic [63:0] cmds [$];
        cmds = cmd_q;
        expect_packet(dest, ip, peer);
        cmd_q.delete();
        @(negedge aclk);
        s_hdr_tdata_i  = {ip, peer, 16'(cmds.size())};
        s_hdr_tdest_i  = dest;
        s_hdr_tvalid_i = 1'b1;
        wait_accept(1'b1, "header");
        foreach (cmds[i]) begin
            @(negedge aclk);
            s_hdr_tvalid_i  = 1'b0;
            s_data_tdata_i  = cmds[i];
            s_data_tlast_i  = (i == cmds.size() - 1);
            s_data_tvalid_i = 1'b1;
            wait_accept(1'b0, "command");
        end
        @(negedge aclk);
        s_data_tvalid_i = 1'b0;
        s_data_tlast_i  = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        while ((exp_bus.size() + exp_hdr.size() + exp_data.size()) != 0
               && n < LIMIT && !timed_out) begin
            @(posedge aclk);
            n++;
        end
        if (n >= LIMIT) begin
            timed_out = 1'b1;
            $display("timeout: %s still waits for %0d bus cycles and %0d reply qwords",
                     name, exp_bus.size(), exp_data.size());
        end
        @(negedge aclk);
    endtask

    task automatic hold_until_backpressure();
        int n;
        n = 0;
        @(posedge aclk);
        ready_mode = 0;
        while (!bp_seen && n < LIMIT && !timed_out) begin
            @(negedge aclk);
            n++;
        end
        @(posedge aclk);
        ready_mode = 1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark || timed_out) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
        err_mark = errors;
    endtask

    initial begin
        arst_n_i        = 1'b0;
        s_hdr_tdata_i   = '0;
        s_hdr_tdest_i   = '0;
        s_hdr_tvalid_i  = 1'b0;
        s_data_tdata_i  = '0;
        s_data_tkeep_i  = 8'hff;
        s_data_tlast_i  = 1'b0;
        s_data_tvalid_i = 1'b0;
        m_hdr_tready_i  = 1'b1;
        m_data_tready_i = 1'b1;
        drop_window     = 1'b0;
        bp_seen         = 1'b0;
        timed_out       = 1'b0;
        errors          = 0;
        err_mark        = 0;
        tests_run       = 0;
        tests_failed    = 0;

        repeat (5) @(posedge aclk);
        a_reset_ready: assert (!s_hdr_tready_o && !s_data_tready_o)
            else report_error("stream ready high during reset");
        @(negedge aclk);
        arst_n_i = 1'b1;
        @(negedge aclk);
        a_reset_quiet: assert (!en_o && !wr_o && !m_hdr_tvalid_o && !m_data_tvalid_o)
            else report_error("bus enable or reply valid high after reset");
        finish_test("reset");

        add_cmd(28'h0000010, 32'h1111aaaa);
        add_cmd(28'h0000024, 32'h2222bbbb);
        add_cmd(28'h0abc038, 32'h3333cccc);
        send_packet(16'd21623, 32'hc0a80101, 16'd40001);
        wait_done("write 21623");
        finish_test("write port 21623");

        add_cmd(28'h0000040, 32'h4444dddd);
        add_cmd(28'h0000044, 32'h5555eeee);
        send_packet(16'd21616, 32'hc0a80102, 16'd40002);
        wait_done("write 21616");
        finish_test("write port 21616");

        // data field of a read command is don't care
        add_cmd(28'h0000010, 32'hdeadbeef);
        add_cmd(28'h0000024, 32'hdeadbeef);
        add_cmd(28'h0abc038, 32'hdeadbeef);
        add_cmd(28'h0000400, 32'hdeadbeef);
        send_packet(READ_PORT, 32'hc0a80103, 16'd40003);
        wait_done("read 21618");
        finish_test("read port 21618");

        drop_window = 1'b1;
        add_cmd(28'h0000010, 32'h0badf00d);
        add_cmd(28'h0000014, 32'h0badf00d);
        send_packet(16'd21603, 32'hc0a80104, 16'd40004);
        add_cmd(28'h0000018, 32'h0badf00d);
        add_cmd(28'h000001c, 32'h0badf00d);
        send_packet(16'd21605, 32'hc0a80104, 16'd40004);
        repeat (16) @(negedge aclk);
        drop_window = 1'b0;
        add_cmd(28'h0000044, 32'h00000000);
        add_cmd(28'h0000010, 32'h00000000);
        send_packet(READ_PORT, 32'hc0a80105, 16'd40005);
        wait_done("dropped ports");
        finish_test("dropped ports 21603 21605");

        // second packet queues behind the first once the output is held
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    add_cmd(28'h0000100 + 28'(i * 4), 32'hc0de0000 + i);
                end
                send_packet(16'd21617, 32'hc0a80106, 16'd40006);
                add_cmd(28'h0000104, 32'h00000000);
                add_cmd(28'h0000114, 32'h00000000);
                send_packet(READ_PORT, 32'hc0a80107, 16'd40007);
            end
            hold_until_backpressure();
        join
        wait_done("ready gaps");
        a_backpressure: assert (bp_seen)
            else report_error("s_data_tready_o never stalled while the output was held");
        @(posedge aclk);
        ready_mode = 2;
        finish_test("reply ready gaps");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb_reg_responder.sv
`timescale 1ns/1ps

// register-bus memory model, acks after delay_i extra cycles
module tb_reg_responder (
    input  logic        aclk,
    input  logic        arst_n_i,
    input  logic        en_i,
    input  logic        wr_i,
    input  logic [27:0] adr_i,
    input  logic [31:0] dat_i,
    input  logic [1:0]  delay_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);
    logic [31:0] mem [logic [27:0]];
    logic        busy = 1'b0;
    logic [1:0]  wait_cnt = '0;
    logic        ack_q = 1'b0;
    logic [31:0] rdata_q = '0;

    assign ack_o = ack_q;
    assign dat_o = rdata_q;

    // outputs change on the falling edge, the DUT samples on the rising one
    always @(negedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy    = 1'b0;
            ack_q   = 1'b0;
            rdata_q = '0;
        end else if (ack_q) begin
            ack_q = 1'b0;
        end else if (en_i) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = delay_i;
            end
            if (wait_cnt == 2'd0) begin
                busy  = 1'b0;
                ack_q = 1'b1;
                if (wr_i) begin
                    mem[adr_i] = dat_i;
                end else begin
                    // unwritten locations read back a pattern of the address
                    rdata_q = mem.exists(adr_i) ? mem[adr_i] : ({4'h0, adr_i} ^ 32'h5a5a5a5a);
                end
            end else begin
                wait_cnt = wait_cnt - 2'd1;
            end
        end
    end

endmodule

//--- turf_udp_ctrl.sv
`timescale 1ns/1ps
`include "udp_ctrl_macros.svh"

module turf_udp_ctrl (
    input  logic                        aclk,
    input  logic                        arst_n_i,
    // inbound from the network stack
    input  logic [63:0]                 s_hdr_tdata_i,
    input  logic [`UDP_PORT_W-1:0]      s_hdr_tdest_i,
    input  logic                        s_hdr_tvalid_i,
    output logic                        s_hdr_tready_o,
    input  logic [`UDP_PAYLOAD_W-1:0]   s_data_tdata_i,
    input  logic [`UDP_PAYLOAD_W/8-1:0] s_data_tkeep_i,
    input  logic                        s_data_tlast_i,
    input  logic                        s_data_tvalid_i,
    output logic                        s_data_tready_o,
    // replies back to the stack
    output logic [63:0]                 m_hdr_tdata_o,
    output logic [`UDP_PORT_W-1:0]      m_hdr_tuser_o,
    output logic                        m_hdr_tvalid_o,
    input  logic                        m_hdr_tready_i,
    output logic [`UDP_PAYLOAD_W-1:0]   m_data_tdata_o,
    output logic [`UDP_PAYLOAD_W/8-1:0] m_data_tkeep_o,
    output logic                        m_data_tlast_o,
    output logic                        m_data_tvalid_o,
    input  logic                        m_data_tready_i,
    // register bus
    output logic                        en_o,
    output logic                        wr_o,
    output logic [`REG_ADR_W-1:0]       adr_o,
    output logic [`REG_DAT_W-1:0]       dat_o,
    input  logic [`REG_DAT_W-1:0]       dat_i,
    input  logic                        ack_i
);

    udp_stream_if req_if ();
    rdwr_reply_if rep_if ();

    udp_port_switch u_switch (
        .aclk            (aclk),
        .arst_n_i        (arst_n_i),
        .s_hdr_tdata_i   (s_hdr_tdata_i),
        .s_hdr_tdest_i   (s_hdr_tdest_i),
        .s_hdr_tvalid_i  (s_hdr_tvalid_i),
        .s_hdr_tready_o  (s_hdr_tready_o),
        .s_data_tdata_i  (s_data_tdata_i),
        .s_data_tkeep_i  (s_data_tkeep_i),
        .s_data_tlast_i  (s_data_tlast_i),
        .s_data_tvalid_i (s_data_tvalid_i),
        .s_data_tready_o (s_data_tready_o),
        .req             (req_if.src)
    );

    udp_rdwr_engine u_rdwr (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .req      (req_if.snk),
        .rep      (rep_if.src),
        .en_o     (en_o),
        .wr_o     (wr_o),
        .adr_o    (adr_o),
        .dat_o    (dat_o),
        .dat_i    (dat_i),
        .ack_i    (ack_i)
    );

    udp_reply_builder u_reply (
        .aclk            (aclk),
        .arst_n_i        (arst_n_i),
        .rep             (rep_if.snk),
        .m_hdr_tdata_o   (m_hdr_tdata_o),
        .m_hdr_tuser_o   (m_hdr_tuser_o),
        .m_hdr_tvalid_o  (m_hdr_tvalid_o),
        .m_hdr_tready_i  (m_hdr_tready_i),
        .m_data_tdata_o  (m_data_tdata_o),
        .m_data_tkeep_o  (m_data_tkeep_o),
        .m_data_tlast_o  (m_data_tlast_o),
        .m_data_tvalid_o (m_data_tvalid_o),
        .m_data_tready_i (m_data_tready_i)
    );

endmodule

//--- udp_reply_builder.sv
`timescale 1ns/1ps
`include "udp_ctrl_macros.svh"

module udp_reply_builder (
    input  logic                        aclk,
    input  logic                        arst_n_i,
    rdwr_reply_if.snk                   rep,
    output logic [63:0]                 m_hdr_tdata_o,
    output logic [`UDP_PORT_W-1:0]      m_hdr_tuser_o,
    output logic                        m_hdr_tvalid_o,
    input  logic                        m_hdr_tready_i,
    output logic [`UDP_PAYLOAD_W-1:0]   m_data_tdata_o,
    output logic [`UDP_PAYLOAD_W/8-1:0] m_data_tkeep_o,
    output logic                        m_data_tlast_o,
    output logic                        m_data_tvalid_o,
    input  logic                        m_data_tready_i
);
    import udp_ctrl_pkg::*;

    localparam int DEPTH = `REPLY_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`UDP_PAYLOAD_W-1:0] qword_mem [DEPTH];
    logic                      last_mem  [DEPTH];
    udp_hdr_t                  hdr_mem   [DEPTH];
    rdwr_op_e                  op_mem    [DEPTH];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [PTR_W:0]            fill_q;
    logic                      push;
    logic                      pop;
    logic                      empty;
    reply_state_e              state_q;

    assign empty     = (fill_q == '0);
    assign rep.ready = (fill_q != (PTR_W+1)'(DEPTH));
    assign push      = rep.valid && rep.ready;
    assign pop       = m_data_tvalid_o && m_data_tready_i;

    always_ff @(posedge aclk) begin
        if (push) begin
            qword_mem[wr_ptr_q] <= rep.qword;
            last_mem[wr_ptr_q]  <= rep.last;
            hdr_mem[wr_ptr_q]   <= rep.hdr;
            op_mem[wr_ptr_q]    <= rep.op;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
            state_q  <= RS_IDLE;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
            case (state_q)
                RS_IDLE: if (!empty) state_q <= RS_HDR;
                RS_HDR:  if (m_hdr_tready_i) state_q <= RS_DATA;
                RS_DATA: if (pop && m_data_tlast_o) state_q <= RS_IDLE;
                default: state_q <= RS_IDLE;
            endcase
        end
    end

    // header comes from the head entry, which stays put until payload pops
    assign m_hdr_tvalid_o = (state_q == RS_HDR);
    assign m_hdr_tdata_o  = hdr_mem[rd_ptr_q];
    assign m_hdr_tuser_o  = (op_mem[rd_ptr_q] == OP_READ) ? `UDP_PORT_READ
                                                          : `UDP_PORT_WRITE_REPLY;

    assign m_data_tvalid_o = (state_q == RS_DATA) && !empty;
    assign m_data_tdata_o  = qword_mem[rd_ptr_q];
    assign m_data_tlast_o  = last_mem[rd_ptr_q];
    assign m_data_tkeep_o  = '1;

    a_no_overflow: assert property (@(posedge aclk) disable iff (!arst_n_i)
        fill_q <= (PTR_W+1)'(DEPTH))
        else $error("reply FIFO overflow");

endmodule

//--- udp_rdwr_engine.sv
`timescale 1ns/1ps
`include "udp_ctrl_macros.svh"

module udp_rdwr_engine (
    input  logic                  aclk,
    input  logic                  arst_n_i,
    udp_stream_if.snk             req,
    rdwr_reply_if.src             rep,
    output logic                  en_o,
    output logic                  wr_o,
    output logic [`REG_ADR_W-1:0] adr_o,
    output logic [`REG_DAT_W-1:0] dat_o,
    input  logic [`REG_DAT_W-1:0] dat_i,
    input  logic                  ack_i
);
    import udp_ctrl_pkg::*;

    localparam int PAD_W = `UDP_PAYLOAD_W - `REG_DAT_W - `REG_ADR_W;

    rdwr_state_e               state_q;
    udp_hdr_t                  hdr_q;
    rdwr_op_e                  op_q;
    logic                      last_cmd_q;
    logic [`UDP_PAYLOAD_W-1:0] reply_q;
    logic                      hdr_fire;
    logic                      cmd_fire;
    logic                      bus_done;
    logic [`REG_DAT_W-1:0]     bus_data;

    assign req.hdr_ready  = (state_q == ST_IDLE);
    assign req.data_ready = (state_q == ST_CMD);

    assign hdr_fire = req.hdr_valid && req.hdr_ready;
    assign cmd_fire = req.data_valid && req.data_ready;
    assign bus_done = (state_q == ST_BUS) && ack_i;

    // writes echo the written data and reads return the bus data
    assign bus_data = wr_o ? dat_o : dat_i;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            en_o    <= 1'b0;
            wr_o    <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req.hdr_valid) begin
                        state_q <= ST_CMD;
                    end
                end
                ST_CMD: begin
                    // bus cycle starts on the next edge
                    if (req.data_valid) begin
                        state_q <= ST_BUS;
                        en_o    <= 1'b1;
                        wr_o    <= (op_q == OP_WRITE);
                    end
                end
                ST_BUS: begin
                    if (ack_i) begin
                        state_q <= ST_REPLY;
                        en_o    <= 1'b0;
                        wr_o    <= 1'b0;
                    end
                end
                ST_REPLY: begin
                    // hold here under back-pressure with no new bus cycle
                    if (rep.ready) begin
                        state_q <= last_cmd_q ? ST_IDLE : ST_CMD;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (hdr_fire) begin
            hdr_q <= req.hdr;
            op_q  <= req.op;
        end
        if (cmd_fire) begin
            // bits 31:28 of the command are don't care
            adr_o      <= req.data[`REG_ADR_W-1:0];
            dat_o      <= req.data[`UDP_PAYLOAD_W-1 -: `REG_DAT_W];
            last_cmd_q <= req.last;
        end
        if (bus_done) begin
            reply_q <= {bus_data, {PAD_W{1'b0}}, adr_o};
        end
    end

    assign rep.valid = (state_q == ST_REPLY);
    assign rep.qword = reply_q;
    assign rep.last  = last_cmd_q;
    assign rep.hdr   = hdr_q;
    assign rep.op    = op_q;

    a_bus_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
        en_o && !ack_i |=> en_o && $stable(adr_o) && $stable(wr_o) && $stable(dat_o))
        else $error("register bus changed before ack");

endmodule

//--- udp_port_switch.sv
`timescale 1ns/1ps
`include "udp_ctrl_macros.svh"

module udp_port_switch (
    input  logic                        aclk,
    input  logic                        arst_n_i,
    input  logic [63:0]                 s_hdr_tdata_i,
    input  logic [`UDP_PORT_W-1:0]      s_hdr_tdest_i,
    input  logic                        s_hdr_tvalid_i,
    output logic                        s_hdr_tready_o,
    input  logic [`UDP_PAYLOAD_W-1:0]   s_data_tdata_i,
    input  logic [`UDP_PAYLOAD_W/8-1:0] s_data_tkeep_i,
    input  logic                        s_data_tlast_i,
    input  logic                        s_data_tvalid_i,
    output logic                        s_data_tready_o,
    udp_stream_if.src                   req
);
    import udp_ctrl_pkg::*;

    logic                      rdy_en_q;
    logic                      pkt_active_q;
    logic                      pkt_drop_q;
    logic                      hdr_valid_q;
    logic                      data_valid_q;
    udp_hdr_t                  hdr_q;
    rdwr_op_e                  op_q;
    logic [`UDP_PAYLOAD_W-1:0] data_q;
    logic                      last_q;
    logic                      is_read;
    logic                      is_write;
    logic                      hdr_fire;
    logic                      data_fire;

    // read port wins, it also sits inside the write range
    assign is_read  = (s_hdr_tdest_i == `UDP_PORT_READ);
    assign is_write = ((s_hdr_tdest_i & ~`UDP_PORT_WRITE_MASK) ==
                       (`UDP_PORT_WRITE_BASE & ~`UDP_PORT_WRITE_MASK));

    // new header only between packets
    assign s_hdr_tready_o  = rdy_en_q && !pkt_active_q && (!hdr_valid_q || req.hdr_ready);
    // dropped packets drain freely
    assign s_data_tready_o = pkt_active_q && (pkt_drop_q || !data_valid_q || req.data_ready);

    assign hdr_fire  = s_hdr_tvalid_i && s_hdr_tready_o;
    assign data_fire = s_data_tvalid_i && s_data_tready_o;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdy_en_q     <= 1'b0;
            pkt_active_q <= 1'b0;
            pkt_drop_q   <= 1'b0;
            hdr_valid_q  <= 1'b0;
            data_valid_q <= 1'b0;
        end else begin
            rdy_en_q <= 1'b1;
            if (hdr_fire) begin
                pkt_active_q <= 1'b1;
                pkt_drop_q   <= !(is_read || is_write);
            end else if (data_fire && s_data_tlast_i) begin
                pkt_active_q <= 1'b0;
            end
            if (hdr_fire && (is_read || is_write)) begin
                hdr_valid_q <= 1'b1;
            end else if (req.hdr_ready) begin
                hdr_valid_q <= 1'b0;
            end
            if (data_fire && !pkt_drop_q) begin
                data_valid_q <= 1'b1;
            end else if (req.data_ready) begin
                data_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (hdr_fire) begin
            hdr_q <= s_hdr_tdata_i;
            op_q  <= is_read ? OP_READ : OP_WRITE;
        end
        if (data_fire && !pkt_drop_q) begin
            data_q <= s_data_tdata_i;
            last_q <= s_data_tlast_i;
        end
    end

    assign req.hdr_valid  = hdr_valid_q;
    assign req.hdr        = hdr_q;
    assign req.op         = op_q;
    assign req.data_valid = data_valid_q;
    assign req.data       = data_q;
    assign req.last       = last_q;

    a_hdr_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
        hdr_valid_q && !req.hdr_ready |=> hdr_valid_q && $stable(hdr_q) && $stable(op_q))
        else $error("switch header changed while stalled");

    a_data_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
        data_valid_q && !req.data_ready |=> data_valid_q && $stable(data_q) && $stable(last_q))
        else $error("switch data changed while stalled");

    // commands are whole qwords
    a_full_keep: assert property (@(posedge aclk) disable iff (!arst_n_i)
        data_fire && !pkt_drop_q |-> &s_data_tkeep_i)
        else $error("partial qword on a command port");

endmodule

//--- udp_stream_if.sv
`timescale 1ns/1ps
`include "udp_ctrl_macros.svh"

// switched request stream, header beat then command qwords
interface udp_stream_if;
    import udp_ctrl_pkg::*;

    logic                      hdr_valid;
    logic                      hdr_ready;
    udp_hdr_t                  hdr;
    rdwr_op_e                  op;
    logic                      data_valid;
    logic                      data_ready;
    logic [`UDP_PAYLOAD_W-1:0] data;
    logic                      last;

    modport src (
        output hdr_valid, hdr, op, data_valid, data, last,
        input  hdr_ready, data_ready
    );

    modport snk (
        input  hdr_valid, hdr, op, data_valid, data, last,
        output hdr_ready, data_ready
    );
endinterface

// one beat per finished command
interface rdwr_reply_if;
    import udp_ctrl_pkg::*;

    logic                      valid;
    logic                      ready;
    logic [`UDP_PAYLOAD_W-1:0] qword;
    logic                      last;
    // repeated on every beat of a reply
    udp_hdr_t                  hdr;
    rdwr_op_e                  op;

    modport src (output valid, qword, last, hdr, op, input ready);

    modport snk (input valid, qword, last, hdr, op, output ready);
endinterface

//--- udp_ctrl_pkg.sv
package udp_ctrl_pkg;

    `include "udp_ctrl_macros.svh"

    // header beat from the network stack, peer side
    typedef struct packed {
        logic [`UDP_IP_W-1:0]   ip;
        logic [`UDP_PORT_W-1:0] port;
        // payload length in qwords
        logic [15:0]            len;
    } udp_hdr_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } rdwr_op_e;

    // register engine
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_BUS,
        ST_REPLY
    } rdwr_state_e;

    // reply sequencer
    typedef enum logic [1:0] {
        RS_IDLE,
        RS_HDR,
        RS_DATA
    } reply_state_e;

endpackage

//--- udp_ctrl_macros.svh
`ifndef UDP_CTRL_MACROS_SVH
`define UDP_CTRL_MACROS_SVH

// stream widths
`define UDP_PAYLOAD_W 64
`define UDP_PORT_W 16
`define UDP_IP_W 32

// simple register bus
`define REG_ADR_W 28
`define REG_DAT_W 32

// 'Tr' read port, exact match
`define UDP_PORT_READ 16'd21618
// 'Tw' write ports 21616 through 21623
`define UDP_PORT_WRITE_BASE 16'd21616
`define UDP_PORT_WRITE_MASK 16'd7
// write replies always leave from 'Tw'
`define UDP_PORT_WRITE_REPLY 16'd21623

`define REPLY_FIFO_DEPTH 4

`endif
